// ==== commit/commitControl.sv ====
`default_nettype none
`timescale 1ns/100ps

module commitControl import commitPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire slotStatus              slotStat [commitWidth],
    input  wire logic [5:0]             irqLines,
    input  wire logic [5:0]             irqMask,
    input  wire logic                   irqEnable,
    output logic [1:0]                  popCount,
    output logic                        flush,
    output logic [commitWidth-1:0]      commitValid,
    output commitRecord                 commitRec [commitWidth],
    output logic [commitWidth-1:0]      storeFire,
    output bpUpdate                     bpUpd [commitWidth],
    output logic                        redirectValid,
    output logic [31:0]                 redirectPc,
    output logic                        excValid,
    output excCode                      excType,
    output logic [31:0]                 excPc
);

    logic [5:0]             irqSample;
    logic                   pending;
    logic [31:0]            epc;
    logic                   takeIrq;
    logic                   halted;
    logic [commitWidth-1:0] retire;
    commitRecord            recNext [commitWidth];

    // interrupt lines sampled once before masking
    always_ff @(posedge clk) begin
        if (rst) begin
            irqSample <= '0;
            pending   <= 1'b0;
        end else begin
            irqSample <= irqLines;
            if (takeIrq) begin
                pending <= 1'b0;
            end else if ((|(irqSample & irqMask)) && irqEnable) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (excValid) begin
            epc <= excPc;
        end
    end

    // retire decision, oldest slot first
    always_comb begin
        takeIrq       = pending && slotStat[0].good;
        halted        = takeIrq;
        retire        = '0;
        popCount      = 2'd0;
        flush         = 1'b0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        excValid      = 1'b0;
        excType       = excNone;
        excPc         = '0;

        if (takeIrq) begin
            flush         = 1'b1;
            redirectValid = 1'b1;
            redirectPc    = excVector;
            excValid      = 1'b1;
            excType       = excInterrupt;
            excPc         = slotStat[0].pc;
        end

        for (int i = 0; i < commitWidth; i++) begin
            if (!halted) begin
                if (!slotStat[i].good) begin
                    halted = 1'b1;
                end else if (slotStat[i].raisesExc) begin
                    // faulting entry never commits
                    halted        = 1'b1;
                    flush         = 1'b1;
                    redirectValid = 1'b1;
                    redirectPc    = excVector;
                    excValid      = 1'b1;
                    excType       = slotStat[i].exc;
                    excPc         = slotStat[i].pc;
                end else begin
                    retire[i] = 1'b1;
                    popCount  = popCount + 2'd1;
                    if (slotStat[i].isEret) begin
                        halted        = 1'b1;
                        flush         = 1'b1;
                        redirectValid = 1'b1;
                        redirectPc    = epc;
                    end else if (slotStat[i].mispredict) begin
                        halted        = 1'b1;
                        flush         = 1'b1;
                        redirectValid = 1'b1;
                        redirectPc    = slotStat[i].redirectPc;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            storeFire[i] = retire[i] && slotStat[i].isStore;
            recNext[i]   = slotStat[i].rec;
            // eret writes no register
            recNext[i].we = slotStat[i].rec.we && !slotStat[i].isEret;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < commitWidth; i++) begin
            commitRec[i] <= recNext[i];
            bpUpd[i]     <= slotStat[i].bp;
        end
        if (rst) begin
            commitValid <= '0;
            for (int i = 0; i < commitWidth; i++) begin
                bpUpd[i].valid <= 1'b0;
            end
        end else begin
            commitValid <= retire;
            for (int i = 0; i < commitWidth; i++) begin
                bpUpd[i].valid <= retire[i] && slotStat[i].bp.valid;
            end
        end
    end

    redirectMatchesFlush: assert property (@(posedge clk) disable iff (rst)
        redirectValid == flush);

    excImpliesRedirect: assert property (@(posedge clk) disable iff (rst)
        excValid |-> redirectValid);

    // queue is empty right after a flush
    noRetireAfterFlush: assert property (@(posedge clk) disable iff (rst)
        flush |=> popCount == 2'd0);

endmodule

`default_nettype wire

// ==== commit/commitSlot.sv ====
`default_nettype none
`timescale 1ns/100ps

module commitSlot import commitPkg::*; (
    input  wire robEntry entry,
    output slotStatus    status
);

    logic isCtl;
    logic good;
    logic raisesExc;
    logic dirWrong;
    logic targetWrong;

    assign good      = entry.valid && entry.done;
    assign isCtl     = entry.uop.kind == kindBranch || entry.uop.kind == kindJump;
    assign raisesExc = good && entry.exc != excNone;

    // target only matters when the branch really went somewhere
    assign dirWrong    = entry.taken != entry.uop.predTaken;
    assign targetWrong = entry.taken && entry.target != entry.uop.predTarget;

    always_comb begin
        status.good       = good;
        status.raisesExc  = raisesExc;
        status.isStore    = good && !raisesExc && entry.uop.kind == kindStore;
        status.isEret     = good && !raisesExc && entry.uop.kind == kindEret;
        status.mispredict = good && !raisesExc && isCtl && (dirWrong || targetWrong);
        status.pc         = entry.uop.pc;
        status.exc        = entry.exc;

        // fall through skips the delay slot
        if (entry.taken) begin
            status.redirectPc = entry.target;
        end else begin
            status.redirectPc = entry.uop.pc + 32'd8;
        end

        status.rec.we    = entry.uop.dstWe;
        status.rec.arch  = entry.uop.dstArch;
        status.rec.phys  = entry.uop.dstPhys;
        status.rec.stale = entry.uop.stalePhys;

        status.bp.valid        = good && !raisesExc && isCtl;
        status.bp.pc           = entry.uop.pc;
        status.bp.taken        = entry.taken;
        status.bp.target       = entry.target;
        status.bp.mispredicted = dirWrong || targetWrong;
    end

    // a completed entry always carries a defined kind
    always_comb begin
        slotKindLegal: assert final (!good
            || entry.uop.kind inside {kindAlu, kindLoad, kindStore, kindBranch, kindJump, kindEret});
    end

endmodule

`default_nettype wire

// ==== commit/commitUnit.sv ====
`default_nettype none
`timescale 1ns/100ps

module commitUnit import commitPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   dispValid,
    input  wire dispatchUop             dispUop,
    output logic [robTagWidth-1:0]      dispTag,
    output logic                        robFull,
    input  wire logic                   cmplValid,
    input  wire completeInfo            cmplInfo,
    input  wire logic [5:0]             irqLines,
    input  wire logic [5:0]             irqMask,
    input  wire logic                   irqEnable,
    output logic [commitWidth-1:0]      commitValid,
    output commitRecord                 commitRec [commitWidth],
    output logic [commitWidth-1:0]      storeFire,
    output bpUpdate                     bpUpd [commitWidth],
    output logic                        redirectValid,
    output logic [31:0]                 redirectPc,
    output logic                        excValid,
    output excCode                      excType,
    output logic [31:0]                 excPc
);

    robEntry    headEntries [commitWidth];
    slotStatus  slotStat [commitWidth];
    logic [1:0] popCount;
    logic       flush;

    robQueue queue (
        .clk         (clk),
        .rst         (rst),
        .dispValid   (dispValid),
        .dispUop     (dispUop),
        .dispTag     (dispTag),
        .robFull     (robFull),
        .cmplValid   (cmplValid),
        .cmplInfo    (cmplInfo),
        .popCount    (popCount),
        .flush       (flush),
        .headEntries (headEntries)
    );

    // one evaluator per head slot
    for (genvar i = 0; i < commitWidth; i++) begin : gSlot
        commitSlot slot (
            .entry  (headEntries[i]),
            .status (slotStat[i])
        );
    end

    commitControl control (
        .clk           (clk),
        .rst           (rst),
        .slotStat      (slotStat),
        .irqLines      (irqLines),
        .irqMask       (irqMask),
        .irqEnable     (irqEnable),
        .popCount      (popCount),
        .flush         (flush),
        .commitValid   (commitValid),
        .commitRec     (commitRec),
        .storeFire     (storeFire),
        .bpUpd         (bpUpd),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .excValid      (excValid),
        .excType       (excType),
        .excPc         (excPc)
    );

endmodule

`default_nettype wire

// ==== common/commitPkg.sv ====
`default_nettype none

package commitPkg;

    // queue geometry
    localparam int robDepth    = 16;
    localparam int robTagWidth = 4;
    localparam int commitWidth = 2;

    // fetch address taken on any exception or interrupt
    localparam logic [31:0] excVector = 32'hbfc0_0380;

    typedef enum logic [2:0] {
        kindAlu,
        kindLoad,
        kindStore,
        kindBranch,
        kindJump,
        kindEret
    } uopKind;

    typedef enum logic [4:0] {
        excNone,
        excInterrupt,
        excAddrLoad,
        excAddrStore,
        excSyscall,
        excOverflow,
        excEret
    } excCode;

    // written by dispatch into the tail entry
    typedef struct packed {
        logic [31:0] pc;
        uopKind      kind;
        logic        dstWe;
        logic [4:0]  dstArch;
        logic [5:0]  dstPhys;
        logic [5:0]  stalePhys;
        logic        predTaken;
        logic [31:0] predTarget;
    } dispatchUop;

    // execution result for one tag
    typedef struct packed {
        logic [robTagWidth-1:0] tag;
        logic                   taken;
        logic [31:0]            target;
        excCode                 exc;
    } completeInfo;

    typedef struct packed {
        dispatchUop  uop;
        logic        valid;
        logic        done;
        logic        taken;
        logic [31:0] target;
        excCode      exc;
    } robEntry;

    // rename free list update
    typedef struct packed {
        logic       we;
        logic [4:0] arch;
        logic [5:0] phys;
        logic [5:0] stale;
    } commitRecord;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        mispredicted;
    } bpUpdate;

    // per slot view handed to the controller
    typedef struct packed {
        logic        good;
        logic        isStore;
        logic        mispredict;
        logic        raisesExc;
        logic        isEret;
        logic [31:0] redirectPc;
        logic [31:0] pc;
        excCode      exc;
        commitRecord rec;
        bpUpdate     bp;
    } slotStatus;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/commitPkg.sv
hw/robQueue.sv
commit/commitSlot.sv
commit/commitControl.sv
commit/commitUnit.sv
verif/commitTb.sv

// ==== hw/robQueue.sv ====
`default_nettype none
`timescale 1ns/100ps

module robQueue import commitPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   dispValid,
    input  wire dispatchUop             dispUop,
    output logic [robTagWidth-1:0]      dispTag,
    output logic                        robFull,
    input  wire logic                   cmplValid,
    input  wire completeInfo            cmplInfo,
    input  wire logic [1:0]             popCount,
    input  wire logic                   flush,
    output robEntry                     headEntries [commitWidth]
);

    // payload storage
    dispatchUop             uopMem [robDepth];
    logic                   resTaken [robDepth];
    logic [31:0]            resTarget [robDepth];
    excCode                 resExc [robDepth];

    logic [robDepth-1:0]    validBits;
    logic [robDepth-1:0]    doneBits;
    logic [robTagWidth-1:0] head;
    logic [robTagWidth-1:0] tail;
    logic [robTagWidth:0]   count;
    logic [robTagWidth-1:0] headNext;
    logic [robTagWidth-1:0] headIdx [commitWidth];
    logic                   push;
    logic                   cmplHit;

    assign robFull  = count == (robTagWidth + 1)'(robDepth);
    assign dispTag  = tail;
    // a dispatch in a flush cycle belongs to the squashed path
    assign push     = dispValid && !robFull && !flush;
    assign cmplHit  = cmplValid && validBits[cmplInfo.tag];
    assign headNext = head + robTagWidth'(popCount);

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            headIdx[i] = head + robTagWidth'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            headEntries[i].uop    = uopMem[headIdx[i]];
            headEntries[i].valid  = validBits[headIdx[i]];
            headEntries[i].done   = doneBits[headIdx[i]];
            headEntries[i].taken  = resTaken[headIdx[i]];
            headEntries[i].target = resTarget[headIdx[i]];
            headEntries[i].exc    = resExc[headIdx[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            uopMem[tail] <= dispUop;
        end
        if (cmplHit) begin
            resTaken[cmplInfo.tag]  <= cmplInfo.taken;
            resTarget[cmplInfo.tag] <= cmplInfo.target;
            resExc[cmplInfo.tag]    <= cmplInfo.exc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            doneBits  <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (cmplHit) begin
                doneBits[cmplInfo.tag] <= 1'b1;
            end
            for (int i = 0; i < commitWidth; i++) begin
                if (popCount > 2'(i)) begin
                    validBits[headIdx[i]] <= 1'b0;
                end
            end
            if (push) begin
                validBits[tail] <= 1'b1;
                doneBits[tail]  <= 1'b0;
            end
            head <= headNext;
            if (flush) begin
                // empty queue, allocation restarts behind the retired entries
                validBits <= '0;
                tail      <= headNext;
                count     <= '0;
            end else begin
                tail  <= tail + robTagWidth'(push);
                count <= count + (robTagWidth + 1)'(push) - (robTagWidth + 1)'(popCount);
            end
        end
    end

    popWithinCount: assert property (@(posedge clk) disable iff (rst)
        popCount <= count);

    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(dispValid && robFull));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the commit back end testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module commitTb -Mdir obj_dir -f filelist.f &&
./obj_dir/VcommitTb ||
{ echo "simulation run failed"; exit 1; }

// ==== verif/commitTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module commitTb import commitPkg::*; ();

    localparam int numUops   = 600;
    localparam int clkPeriod = 10;

    logic                   clk;
    logic                   rst;
    logic                   dispValid;
    dispatchUop             dispUop;
    logic [robTagWidth-1:0] dispTag;
    logic                   robFull;
    logic                   cmplValid;
    completeInfo            cmplInfo;
    logic [5:0]             irqLines;
    logic [5:0]             irqMask;
    logic                   irqEnable;
    logic [commitWidth-1:0] commitValid;
    commitRecord            commitRec [commitWidth];
    logic [commitWidth-1:0] storeFire;
    bpUpdate                bpUpd [commitWidth];
    logic                   redirectValid;
    logic [31:0]            redirectPc;
    logic                   excValid;
    excCode                 excType;
    logic [31:0]            excPc;

    // reference queue mirror
    dispatchUop             mUop [robDepth];
    logic                   mTaken [robDepth];
    logic [31:0]            mTarget [robDepth];
    excCode                 mExc [robDepth];
    logic [robDepth-1:0]    mValid;
    logic [robDepth-1:0]    mDone;
    logic [robTagWidth-1:0] mHead;
    logic [robTagWidth-1:0] mTail;
    int                     mCount;
    logic [31:0]            mEpc;
    logic                   mPending;
    logic [5:0]             mIrqSample;

    // decision for the current cycle
    logic [1:0]             eRetire;
    logic [1:0]             eStore;
    logic                   eFlush;
    logic [31:0]            eRedirPc;
    logic                   eExc;
    excCode                 eExcType;
    logic [31:0]            eExcPc;

    // registered outputs due after the edge
    logic [1:0]             rValid;
    commitRecord            rRec [commitWidth];
    bpUpdate                rBp [commitWidth];

    logic [31:0]            rng;
    int                     dispatched;

    commitUnit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkFlags(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkRec(input string name, input commitRecord got, input commitRecord exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkBp(input string name, input bpUpdate got, input bpUpdate exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkExc(input string name, input excCode got, input excCode exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkPc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    function automatic dispatchUop makeUop(input logic [31:0] a, input logic [31:0] b);
        dispatchUop u;
        u.pc = {a[31:2], 2'b00};
        case (b[3:0])
            4'd7, 4'd8:   u.kind = kindLoad;
            4'd9, 4'd10:  u.kind = kindStore;
            4'd11, 4'd12: u.kind = kindBranch;
            4'd13, 4'd14: u.kind = kindJump;
            4'd15:        u.kind = kindEret;
            default:      u.kind = kindAlu;
        endcase
        u.dstWe      = b[4];
        u.dstArch    = b[9:5];
        u.dstPhys    = b[15:10];
        u.stalePhys  = b[21:16];
        u.predTaken  = b[22];
        u.predTarget = {a[11:2], b[31:12], 2'b00};
        return u;
    endfunction

    function automatic logic isCtl(input logic [3:0] t);
        return mUop[t].kind inside {kindBranch, kindJump};
    endfunction

    // a not-taken branch has no target to get wrong
    function automatic logic predWrong(input logic [3:0] t);
        return mTaken[t] != mUop[t].predTaken
            || (mTaken[t] && mTarget[t] != mUop[t].predTarget);
    endfunction

    task automatic decide();
        logic       stop;
        logic [3:0] t;
        eRetire  = '0;
        eFlush   = 1'b0;
        eRedirPc = '0;
        eExc     = 1'b0;
        eExcType = excNone;
        eExcPc   = '0;
        stop     = 1'b0;
        if (mPending && mValid[mHead] && mDone[mHead]) begin
            // interrupt blocks both slots
            eFlush   = 1'b1;
            eRedirPc = excVector;
            eExc     = 1'b1;
            eExcType = excInterrupt;
            eExcPc   = mUop[mHead].pc;
            stop     = 1'b1;
        end
        for (int k = 0; k < commitWidth; k++) begin
            t = mHead + 4'(k);
            if (stop || !(mValid[t] && mDone[t])) begin
                stop = 1'b1;
            end else if (mExc[t] != excNone) begin
                eFlush   = 1'b1;
                eRedirPc = excVector;
                eExc     = 1'b1;
                eExcType = mExc[t];
                eExcPc   = mUop[t].pc;
                stop     = 1'b1;
            end else begin
                eRetire[k] = 1'b1;
                if (mUop[t].kind == kindEret) begin
                    eFlush   = 1'b1;
                    eRedirPc = mEpc;
                    stop     = 1'b1;
                end else if (isCtl(t) && predWrong(t)) begin
                    eFlush   = 1'b1;
                    eRedirPc = mTaken[t] ? mTarget[t] : mUop[t].pc + 32'd8;
                    stop     = 1'b1;
                end
            end
            eStore[k] = eRetire[k] && mUop[t].kind == kindStore;
        end
    endtask

    task automatic checkOutputs();
        checkFlags("redirectValid", 8'(redirectValid), 8'(eFlush));
        checkFlags("excValid", 8'(excValid), 8'(eExc));
        checkFlags("storeFire", 8'(storeFire), 8'(eStore));
        checkFlags("commitValid", 8'(commitValid), 8'(rValid));
        checkFlags("dispTag", 8'(dispTag), 8'(mTail));
        checkFlags("robFull", 8'(robFull), 8'(mCount == robDepth));
        if (eFlush) begin
            checkPc("redirectPc", redirectPc, eRedirPc);
        end
        if (eExc) begin
            checkExc("excType", excType, eExcType);
            checkPc("excPc", excPc, eExcPc);
        end
        for (int k = 0; k < commitWidth; k++) begin
            checkFlags($sformatf("bpUpd[%0d].valid", k), 8'(bpUpd[k].valid), 8'(rBp[k].valid));
            if (rValid[k]) begin
                checkRec($sformatf("commitRec[%0d]", k), commitRec[k], rRec[k]);
            end
            if (rBp[k].valid) begin
                checkBp($sformatf("bpUpd[%0d]", k), bpUpd[k], rBp[k]);
            end
        end
    endtask

    task automatic cycleStep(input logic feed);
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  t;
        logic        hit;
        logic        push;
        logic [1:0]  pop;
        int          off;
        decide();
        checkOutputs();
        rValid = eRetire;
        for (int k = 0; k < commitWidth; k++) begin
            t = mHead + 4'(k);
            rRec[k] = '{mUop[t].dstWe && mUop[t].kind != kindEret, mUop[t].dstArch,
                        mUop[t].dstPhys, mUop[t].stalePhys};
            rBp[k] = '{eRetire[k] && isCtl(t), mUop[t].pc, mTaken[t], mTarget[t], predWrong(t)};
        end

        roll(a);
        roll(b);
        dispValid = feed && mCount < robDepth && a[1:0] != 2'd0;
        dispUop   = makeUop(a, b);
        roll(a);
        irqLines  = (feed && a[5:0] == 6'd0) ? a[11:6] : 6'd0;
        irqEnable = a[15:13] != 3'd0;
        cmplValid = 1'b0;
        if (mCount > 0 && a[17:16] != 2'd0) begin
            off = int'(a[27:20]) % mCount;
            for (int k = 0; k < mCount; k++) begin
                t = mHead + 4'((off + k) % mCount);
                if (!cmplValid && !mDone[t]) begin
                    cmplValid    = 1'b1;
                    cmplInfo.tag = t;
                end
            end
        end
        roll(b);
        t = cmplInfo.tag;
        cmplInfo.taken  = isCtl(t) ? (mUop[t].predTaken ^ (b[3:0] == 4'd0)) : b[0];
        cmplInfo.target = (b[7:4] == 4'd0) ? {b[31:10], 10'h0} : mUop[t].predTarget;
        // faults are rare
        cmplInfo.exc    = (b[12:8] == 5'd0) ? excCode'(5'd2 + 5'(b[14:13])) : excNone;

        // advance the mirror as the next rising edge will
        pop  = 2'(eRetire[0]) + 2'(eRetire[1]);
        hit  = cmplValid && mValid[cmplInfo.tag];
        push = dispValid && !eFlush;
        if (hit) begin
            mDone[cmplInfo.tag]   = 1'b1;
            mTaken[cmplInfo.tag]  = cmplInfo.taken;
            mTarget[cmplInfo.tag] = cmplInfo.target;
            mExc[cmplInfo.tag]    = cmplInfo.exc;
        end
        for (int k = 0; k < int'(pop); k++) begin
            mValid[mHead + 4'(k)] = 1'b0;
        end
        if (push) begin
            mUop[mTail]   = dispUop;
            mValid[mTail] = 1'b1;
            mDone[mTail]  = 1'b0;
            dispatched++;
        end
        mHead = mHead + 4'(pop);
        if (eFlush) begin
            mValid = '0;
            mTail  = mHead;
            mCount = 0;
        end else begin
            mTail  = mTail + 4'(push);
            mCount = mCount + int'(push) - int'(pop);
        end
        if (eExc) begin
            mEpc = eExcPc;
        end
        if (eExc && eExcType == excInterrupt) begin
            mPending = 1'b0;
        end else if ((|(mIrqSample & irqMask)) && irqEnable) begin
            mPending = 1'b1;
        end
        mIrqSample = irqLines;
    endtask

    initial begin
        rng        = 32'he37a;
        rst        = 1'b1;
        dispValid  = 1'b0;
        dispUop    = '0;
        cmplValid  = 1'b0;
        cmplInfo   = '0;
        irqLines   = '0;
        irqMask    = 6'h2d;
        irqEnable  = 1'b0;
        mValid     = '0;
        mDone      = '0;
        mHead      = '0;
        mTail      = '0;
        mCount     = 0;
        mEpc       = '0;
        mPending   = 1'b0;
        mIrqSample = '0;
        rValid     = '0;
        dispatched = 0;
        for (int k = 0; k < robDepth; k++) begin
            mUop[k]    = '0;
            mTaken[k]  = 1'b0;
            mTarget[k] = '0;
            mExc[k]    = excNone;
        end
        for (int k = 0; k < commitWidth; k++) begin
            rRec[k] = '0;
            rBp[k]  = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (dispatched < numUops || mCount != 0) begin
            cycleStep(dispatched < numUops);
            @(negedge clk);
        end
        // drained queue, all outputs must go quiet
        repeat (4) begin
            cycleStep(1'b0);
            @(negedge clk);
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        #(numUops * 40 * clkPeriod);
        abortRun("timeout, the queue did not drain in time");
    end

endmodule

`default_nettype wire
